/* rtl/sbox_pkg.sv */
////////////////////////////////////////////////////////////
// switchbox package
// lane count, word width, select and count widths
// typedefs for lane masks, data words, indices and counts
////////////////////////////////////////////////////////////

package sbox_pkg;

   // physical lanes, and logical slots of the same number
   localparam int num_channels = 4;

   // payload width of one lane
   localparam int channel_width = 16;

   // bits to index one lane
   localparam int sel_width = $clog2(num_channels);

   // count runs from 0 up to num_channels inclusive
   localparam int cnt_width = sel_width + 1;

   // one bit per lane: masks, valids, readies, one-hot selects
   typedef logic [num_channels-1:0] chan_mask_t;

   // one data word
   typedef logic [channel_width-1:0] chan_word_t;

   // lane index
   typedef logic [sel_width-1:0] chan_idx_t;

   // number of active lanes
   typedef logic [cnt_width-1:0] chan_cnt_t;

endpackage

/* rtl/scatter_gather.sv */
////////////////////////////////////////////////////////////
// lane route decode for the switchbox
// ranks active physical lanes and builds one-hot selects
// forward select per logical slot, backward per physical lane
// active lane count from the same rank scan
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module scatter_gather
   import sbox_pkg::*;
(
   input  chan_mask_t channel_active_i,
   output chan_mask_t fwd_sel_o [num_channels],
   output chan_mask_t bk_sel_o [num_channels],
   output chan_cnt_t  active_cnt_o
);

   // number of active lanes below each lane
   chan_idx_t rank [num_channels];

   // running count of active lanes
   chan_cnt_t run_cnt;

   // route hit, physical lane k feeds logical slot r
   logic hit [num_channels][num_channels];

   always_comb
   begin
      run_cnt = '0;
      for (int k = 0; k < num_channels; k++)
      begin
         // lane k never has more than k lanes below it
         rank[k] = run_cnt[sel_width-1:0];
         if (channel_active_i[k])
         begin
            run_cnt = run_cnt + chan_cnt_t'(1);
         end
      end
   end

   assign active_cnt_o = run_cnt;

   always_comb
   begin
      for (int r = 0; r < num_channels; r++)
      begin
         for (int k = 0; k < num_channels; k++)
         begin
            hit[r][k] = channel_active_i[k] && (rank[k] == chan_idx_t'(r));
         end
      end
   end

   // same hits seen from both ends
   always_comb
   begin
      for (int r = 0; r < num_channels; r++)
      begin
         for (int k = 0; k < num_channels; k++)
         begin
            // slot r picks up lane k
            fwd_sel_o[r][k] = hit[r][k];
            // lane k sends slot r back out
            bk_sel_o[k][r] = hit[r][k];
         end
      end
   end

endmodule

/* rtl/two_fifo.sv */
////////////////////////////////////////////////////////////
// two-entry lane buffer
// valid/ready on the write side, valid/yumi on the read side
// one-bit read and write pointers, full and empty flags
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module two_fifo
   import sbox_pkg::*;
(
   input  logic       clk_i,
   input  logic       rst_n_i,
   input  logic       v_i,
   input  chan_word_t data_i,
   output logic       ready_o,
   output logic       v_o,
   output chan_word_t data_o,
   input  logic       yumi_i
);

   // storage
   chan_word_t mem [2];

   logic wr_ptr_r;
   logic rd_ptr_r;
   logic full_r;
   logic empty_r;

   logic enq;
   logic deq;

   assign ready_o = ~full_r;
   assign v_o     = ~empty_r;
   assign data_o  = mem[rd_ptr_r];

   assign enq = v_i & ~full_r;
   // yumi only counts with a word present
   assign deq = yumi_i & ~empty_r;

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         wr_ptr_r <= 1'b0;
         rd_ptr_r <= 1'b0;
         full_r   <= 1'b0;
         empty_r  <= 1'b1;
      end
      else
      begin
         if (enq)
         begin
            wr_ptr_r <= ~wr_ptr_r;
         end
         if (deq)
         begin
            rd_ptr_r <= ~rd_ptr_r;
         end
         // level changes only when one side moves alone
         if (enq && !deq)
         begin
            empty_r <= 1'b0;
            full_r  <= (~wr_ptr_r == rd_ptr_r);
         end
         else if (deq && !enq)
         begin
            full_r  <= 1'b0;
            empty_r <= (~rd_ptr_r == wr_ptr_r);
         end
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (enq)
      begin
         mem[wr_ptr_r] <= data_i;
      end
   end

endmodule

/* rtl/sbox.sv */
////////////////////////////////////////////////////////////
// channel switchbox top level
// packs active physical lanes into low logical slots inward
// spreads logical slots back to active lanes outward
// registered one-hot selects, two-entry buffer per lane and way
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sbox
   import sbox_pkg::*;
(
   input  logic       clk_i,
   input  logic       rst_n_i,
   input  logic       calibration_done_i,
   input  chan_mask_t channel_active_i,

   // physical to logical
   input  chan_mask_t in_v_i,
   input  chan_word_t in_data_i [num_channels],
   output chan_mask_t in_yumi_o,

   output chan_mask_t in_v_o,
   output chan_word_t in_data_o [num_channels],
   input  chan_mask_t in_yumi_i,

   // logical to physical
   input  chan_mask_t out_me_v_i,
   input  chan_word_t out_me_data_i [num_channels],
   output chan_mask_t out_me_ready_o,

   output chan_mask_t out_me_v_o,
   output chan_word_t out_me_data_o [num_channels],
   input  chan_mask_t out_me_ready_i
);

   // decoded routes
   chan_mask_t fwd_sel [num_channels];
   chan_mask_t bk_sel [num_channels];
   chan_cnt_t  active_cnt;

   chan_mask_t fwd_sel_r [num_channels];
   chan_mask_t bk_sel_r [num_channels];
   chan_cnt_t  active_cnt_r;

   // inward side, indexed by logical slot
   chan_mask_t in_mux_v;
   chan_word_t in_mux_data [num_channels];
   chan_mask_t in_buf_ready;
   chan_mask_t in_take;

   // outward side, indexed by logical slot
   chan_mask_t slot_en;
   chan_mask_t out_buf_ready;
   chan_mask_t out_buf_v;
   chan_word_t out_buf_data [num_channels];
   chan_mask_t out_buf_pop;

   scatter_gather u_decode
   (
      .channel_active_i (channel_active_i),
      .fwd_sel_o        (fwd_sel),
      .bk_sel_o         (bk_sel),
      .active_cnt_o     (active_cnt)
   );

   // one register stage on the decode
   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         fwd_sel_r    <= '{default: '0};
         bk_sel_r     <= '{default: '0};
         active_cnt_r <= '0;
      end
      else
      begin
         fwd_sel_r    <= fwd_sel;
         bk_sel_r     <= bk_sel;
         active_cnt_r <= active_cnt;
      end
   end

   // inward mux, handshake and yumi steering
   always_comb
   begin
      for (int r = 0; r < num_channels; r++)
      begin
         in_mux_v[r]    = |(in_v_i & fwd_sel_r[r]);
         in_mux_data[r] = '0;
         for (int k = 0; k < num_channels; k++)
         begin
            in_mux_data[r] = in_mux_data[r]
                           | (in_data_i[k] & {channel_width{fwd_sel_r[r][k]}});
         end
         // word is taken only once calibrated
         in_take[r] = in_mux_v[r] & in_buf_ready[r] & calibration_done_i;
      end
      // yumi goes back to whichever lane fed the slot
      for (int k = 0; k < num_channels; k++)
      begin
         in_yumi_o[k] = |(in_take & bk_sel_r[k]);
      end
   end

   // outward gating and lane spreading
   always_comb
   begin
      for (int r = 0; r < num_channels; r++)
      begin
         // slots past the active count stay closed
         slot_en[r]        = chan_cnt_t'(r) < active_cnt_r;
         out_me_ready_o[r] = out_buf_ready[r] & slot_en[r] & calibration_done_i;
         // pop when the mapped physical lane is ready
         out_buf_pop[r]    = out_buf_v[r] & |(out_me_ready_i & fwd_sel_r[r]);
      end
      for (int k = 0; k < num_channels; k++)
      begin
         out_me_v_o[k]    = |(out_buf_v & bk_sel_r[k]);
         out_me_data_o[k] = '0;
         for (int r = 0; r < num_channels; r++)
         begin
            out_me_data_o[k] = out_me_data_o[k]
                             | (out_buf_data[r] & {channel_width{bk_sel_r[k][r]}});
         end
      end
   end

   // one buffer per way on every lane
   for (genvar i = 0; i < num_channels; i++)
   begin : g_lane
      two_fifo u_in_buf
      (
         .clk_i   (clk_i),
         .rst_n_i (rst_n_i),
         .v_i     (in_mux_v[i] & calibration_done_i),
         .data_i  (in_mux_data[i]),
         .ready_o (in_buf_ready[i]),
         .v_o     (in_v_o[i]),
         .data_o  (in_data_o[i]),
         .yumi_i  (in_yumi_i[i])
      );

      two_fifo u_out_buf
      (
         .clk_i   (clk_i),
         .rst_n_i (rst_n_i),
         .v_i     (out_me_v_i[i] & slot_en[i] & calibration_done_i),
         .data_i  (out_me_data_i[i]),
         .ready_o (out_buf_ready[i]),
         .v_o     (out_buf_v[i]),
         .data_o  (out_buf_data[i]),
         .yumi_i  (out_buf_pop[i])
      );
   end

endmodule

/* sim/tb_clk_gen.sv */
////////////////////////////////////////////////////////////
// testbench clock and reset source
// 10 ns clock, active-low reset held for two cycles
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_clk_gen
(
   output logic clk_o,
   output logic rst_n_o
);

   initial
   begin
      clk_o = 1'b0;
      forever #5 clk_o = ~clk_o;
   end

   initial
   begin
      rst_n_o = 1'b0;
      repeat (2) @(posedge clk_o);
      rst_n_o <= 1'b1;
   end

endmodule

/* sim/sbox_sva.sv */
////////////////////////////////////////////////////////////
// switchbox assertions, bound into sbox
// yumi only with valid, outputs inside the active count,
// no handshake before calibration
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sbox_sva
   import sbox_pkg::*;
(
   input logic       clk_i,
   input logic       rst_n_i,
   input logic       calibration_done_i,
   input chan_mask_t channel_active_i,
   input chan_mask_t in_v_i,
   input chan_mask_t in_yumi_o,
   input chan_mask_t in_v_o,
   input chan_mask_t out_me_ready_o
);

   // read back by the testbench at the end of the run
   int unsigned assert_errs = 0;

   // logical slots below the number of lanes set in a mask
   function automatic chan_mask_t slots_below(chan_mask_t mask);
      chan_mask_t slots;
      int n;
      n = $countones(mask);
      for (int r = 0; r < num_channels; r++)
      begin
         slots[r] = (r < n);
      end
      return slots;
   endfunction

   a_yumi_with_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (in_yumi_o & ~in_v_i) == '0)
   else
   begin
      assert_errs++;
      $error("in_yumi_o high on a lane without in_v_i");
   end

   // routing follows the mask seen one edge earlier
   a_inside_count: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      ((in_v_o | out_me_ready_o) & ~slots_below($past(channel_active_i))) == '0)
   else
   begin
      assert_errs++;
      $error("valid or ready on a slot past the active count");
   end

   a_calibration_gate: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !calibration_done_i |-> (in_yumi_o == '0 && out_me_ready_o == '0))
   else
   begin
      assert_errs++;
      $error("handshake given before calibration done");
   end

endmodule

bind sbox sbox_sva u_sva (.*);

/* sim/sbox_tb.sv */
////////////////////////////////////////////////////////////
// switchbox testbench
// stimulus table applied in a loop, rank-rule scoreboard,
// back-pressure and calibration checks, watchdog
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sbox_tb
   import sbox_pkg::*;
();

   typedef struct packed {
      chan_mask_t mask;
      logic       cal;
      chan_mask_t valid;
      chan_word_t key;
      logic       stall;
   } entry_t;

   localparam int num_entries = 8;
   localparam int cal_hold    = 4;
   localparam int stall_len   = 8;
   localparam int min_cycles  = 12;

   logic clk;
   logic rst_n;
   logic calibration_done_i;
   chan_mask_t channel_active_i;
   chan_mask_t in_v_i;
   chan_word_t in_data_i [num_channels];
   chan_mask_t in_yumi_o;
   chan_mask_t in_v_o;
   chan_word_t in_data_o [num_channels];
   chan_mask_t in_yumi_i;
   chan_mask_t out_me_v_i;
   chan_word_t out_me_data_i [num_channels];
   chan_mask_t out_me_ready_o;
   chan_mask_t out_me_v_o;
   chan_word_t out_me_data_o [num_channels];
   chan_mask_t out_me_ready_i;

   entry_t tests [num_entries];
   integer seed;
   int errors;
   int checks;
   int cyc;
   int total_errs;
   // words waiting to be sent and words still expected per lane or slot
   chan_word_t in_send_q [num_channels][$];
   chan_word_t in_exp_q [num_channels][$];
   chan_word_t out_send_q [num_channels][$];
   chan_word_t out_exp_q [num_channels][$];
   int in_acc [num_channels];
   int out_acc [num_channels];

   tb_clk_gen u_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

   sbox dut (.clk_i(clk), .rst_n_i(rst_n), .*);

   task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("error at %0t: %s, got %0h expected %0h", $time, what, got, exp);
      end
   endtask

   // logical slot of physical lane k or -1 when k is inactive
   function automatic int slot_of_lane(chan_mask_t mask, int k);
      int below;
      below = 0;
      for (int j = 0; j < k; j++)
         if (mask[j])
            below++;
      return mask[k] ? below : -1;
   endfunction

   function automatic int lane_of_slot(chan_mask_t mask, int r);
      int lane;
      lane = -1;
      for (int k = 0; k < num_channels; k++)
         if (slot_of_lane(mask, k) == r)
            lane = k;
      return lane;
   endfunction

   task automatic load_entry(input entry_t t);
      int n;
      int slot;
      int lane;
      chan_word_t word;
      // under stall each lane gets one word more than a buffer holds
      n = t.stall ? 3 : 1;
      for (int i = 0; i < num_channels; i++)
      begin
         in_send_q[i].delete();
         in_exp_q[i].delete();
         out_send_q[i].delete();
         out_exp_q[i].delete();
         in_acc[i] = 0;
         out_acc[i] = 0;
      end
      for (int i = 0; i < num_channels; i++)
      begin
         slot = slot_of_lane(t.mask, i);
         lane = lane_of_slot(t.mask, i);
         for (int w = 0; w < n; w++)
         begin
            word = chan_word_t'($random(seed)) ^ t.key;
            if (t.valid[i])
               in_send_q[i].push_back(word);
            if (t.valid[i] && slot >= 0)
               in_exp_q[slot].push_back(word);
            word = chan_word_t'($random(seed)) ^ t.key;
            out_send_q[i].push_back(word);
            if (lane >= 0)
               out_exp_q[lane].push_back(word);
         end
      end
   endtask

   function automatic logic work_left(entry_t t);
      logic busy;
      busy = 1'b0;
      for (int i = 0; i < num_channels; i++)
      begin
         if (t.mask[i] && in_send_q[i].size() != 0)
            busy = 1'b1;
         if (i < $countones(t.mask) && out_send_q[i].size() != 0)
            busy = 1'b1;
         if (in_exp_q[i].size() != 0 || out_exp_q[i].size() != 0)
            busy = 1'b1;
      end
      return busy;
   endfunction

   task automatic run_cycle(input entry_t t, input int c);
      int cnt;
      logic hold;
      cnt = $countones(t.mask);
      hold = t.stall && (c < stall_len);
      @(negedge clk);
      // consumer side with registered outputs settled
      for (int i = 0; i < num_channels; i++)
      begin
         if (in_v_o[i])
         begin
            check_value(i < cnt, 1, $sformatf("in_v_o[%0d] past active count", i));
            check_value(in_exp_q[i].size() != 0, 1, $sformatf("word expected on slot %0d", i));
            if (!hold && in_exp_q[i].size() != 0)
               check_value(in_data_o[i], in_exp_q[i].pop_front(), $sformatf("in_data_o[%0d]", i));
         end
         if (out_me_v_o[i])
         begin
            check_value(t.mask[i], 1, $sformatf("out_me_v_o on inactive lane %0d", i));
            check_value(out_exp_q[i].size() != 0, 1, $sformatf("word expected on lane %0d", i));
            if (!hold && out_exp_q[i].size() != 0)
               check_value(out_me_data_o[i], out_exp_q[i].pop_front(),
                           $sformatf("out_me_data_o[%0d]", i));
         end
      end
      for (int i = 0; i < num_channels; i++)
      begin
         in_yumi_i[i]     = in_v_o[i] & ~hold;
         in_v_i[i]        = in_send_q[i].size() != 0;
         in_data_i[i]     = in_v_i[i] ? in_send_q[i][0] : '0;
         out_me_v_i[i]    = out_send_q[i].size() != 0;
         out_me_data_i[i] = out_me_v_i[i] ? out_send_q[i][0] : '0;
      end
      out_me_ready_i     = hold ? '0 : '1;
      calibration_done_i = t.cal | (c >= cal_hold);
      #1;
      // producer side handshakes for this cycle's inputs
      for (int i = 0; i < num_channels; i++)
      begin
         if (in_yumi_o[i])
         begin
            check_value(t.mask[i], 1, $sformatf("in_yumi_o on inactive lane %0d", i));
            if (in_send_q[i].size() != 0)
               void'(in_send_q[i].pop_front());
            in_acc[i]++;
         end
         if (out_me_ready_o[i])
         begin
            check_value(i < cnt, 1, $sformatf("out_me_ready_o[%0d] past active count", i));
            if (out_me_v_i[i])
            begin
               void'(out_send_q[i].pop_front());
               out_acc[i]++;
            end
         end
         if (hold && c == stall_len - 1)
         begin
            if (t.mask[i] && t.valid[i])
               check_value(in_acc[i], 2, $sformatf("words taken on lane %0d under stall", i));
            if (i < cnt)
               check_value(out_acc[i], 2, $sformatf("words taken on slot %0d under stall", i));
         end
      end
      if (!calibration_done_i)
      begin
         check_value(in_yumi_o, 0, "in_yumi_o before calibration");
         check_value(out_me_ready_o, 0, "out_me_ready_o before calibration");
         check_value(in_v_o, 0, "in_v_o before calibration");
         check_value(out_me_v_o, 0, "out_me_v_o before calibration");
      end
   endtask

   initial
   begin
      repeat (num_entries * 50) @(posedge clk);
      $display("timeout: run did not finish within %0d cycles", num_entries * 50);
      $display("Test failed");
      $finish;
   end

   initial
   begin
      seed = 32'hcc12;
      errors = 0;
      checks = 0;
      calibration_done_i = 1'b0;
      channel_active_i = '0;
      in_v_i = '0;
      in_data_i = '{default: '0};
      in_yumi_i = '0;
      out_me_v_i = '0;
      out_me_data_i = '{default: '0};
      out_me_ready_i = '0;
      //          mask     cal   valid    key       stall
      tests[0] = '{4'b1111, 1'b1, 4'b1111, 16'h0000, 1'b0};
      tests[1] = '{4'b1010, 1'b1, 4'b1111, 16'h1111, 1'b0};
      tests[2] = '{4'b0110, 1'b0, 4'b0110, 16'h2222, 1'b0};
      tests[3] = '{4'b1101, 1'b1, 4'b1101, 16'h3333, 1'b1};
      tests[4] = '{4'b0001, 1'b1, 4'b1111, 16'h4444, 1'b0};
      tests[5] = '{4'b1000, 1'b0, 4'b1001, 16'h5555, 1'b1};
      tests[6] = '{4'b0000, 1'b1, 4'b1111, 16'h6666, 1'b0};
      tests[7] = '{4'b1011, 1'b1, 4'b1011, 16'h7777, 1'b1};
      @(posedge rst_n);
      @(negedge clk);
      // open every lane so only the reset selects keep the handshakes low
      channel_active_i = '1;
      calibration_done_i = 1'b1;
      in_v_i = '1;
      in_yumi_i = '1;
      out_me_v_i = '1;
      out_me_ready_i = '1;
      #1;
      check_value(in_v_o, 0, "in_v_o after reset");
      check_value(in_yumi_o, 0, "in_yumi_o after reset");
      check_value(out_me_v_o, 0, "out_me_v_o after reset");
      check_value(out_me_ready_o, 0, "out_me_ready_o after reset");
      for (int e = 0; e < num_entries; e++)
      begin
         load_entry(tests[e]);
         @(negedge clk);
         // buffers are empty here so the mask may change
         in_v_i = '0;
         in_yumi_i = '0;
         out_me_v_i = '0;
         out_me_ready_i = '0;
         channel_active_i = tests[e].mask;
         calibration_done_i = tests[e].cal;
         @(negedge clk);
         cyc = 0;
         while (cyc < min_cycles || work_left(tests[e]))
         begin
            run_cycle(tests[e], cyc);
            cyc++;
         end
      end
      total_errs = errors + dut.u_sva.assert_errs;
      $display("checks: %0d, errors: %0d, assertion failures: %0d",
               checks, errors, dut.u_sva.assert_errs);
      if (total_errs == 0)
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   end

endmodule

/* list.f */
rtl/sbox_pkg.sv
rtl/scatter_gather.sv
rtl/two_fifo.sv
rtl/sbox.sv
sim/tb_clk_gen.sv
sim/sbox_sva.sv
sim/sbox_tb.sv

/* Bender.yml */
package:
  name: sbox

sources:
  - rtl/sbox_pkg.sv
  - rtl/scatter_gather.sv
  - rtl/two_fifo.sv
  - rtl/sbox.sv
  - target: simulation
    files:
      - sim/tb_clk_gen.sv
      - sim/sbox_sva.sv
      - sim/sbox_tb.sv
